//--- common/core_defs.svh
// Core width and address macros
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data and instruction width
`define XLEN 32

// Significant address bits, upper bits padded with zeros
`define ADDR_WIDTH 24

// First fetch address after reset
`define RESET_ADDR 32'h0000_0000

// Integer register count, gives a 5-bit index
`define NUM_REGS 32

`endif

//--- common/rvPkg.sv
// RV32I core types
package rvPkg;

   // Fetch/execute sequence of the core
   typedef enum logic [2:0] {
      stFetch,
      stWaitInstr,
      stExecute1,
      stExecute2,
      stWaitMem
   } coreState_t;

   // Instruction class from opcode bits 6:2
   typedef enum logic [3:0] {
      opLoad,
      opStore,
      opAluImm,
      opAluReg,
      opLui,
      opAuipc,
      opBranch,
      opJal,
      opJalr,
      opIllegal
   } opGroup_t;

   // Arithmetic meaning of funct3
   // Branches reuse the same encodings for their compare kinds
   typedef enum logic [2:0] {
      aluAddSub = 3'd0,
      aluSll    = 3'd1,
      aluSlt    = 3'd2,
      aluSltu   = 3'd3,
      aluXor    = 3'd4,
      aluSrlSra = 3'd5,
      aluOr     = 3'd6,
      aluAnd    = 3'd7
   } aluOp_t;

endpackage

//--- source/instrDecoder.sv
// RV32I instruction decoder
`include "core_defs.svh"

module instrDecoder (
   input  logic               clk,
   input  logic               capture,
   input  logic [`XLEN-1:0]   memRdata,
   output rvPkg::opGroup_t    opGroup,
   output rvPkg::aluOp_t      funct3,
   output logic [4:0]         rdIdx,
   output logic [4:0]         rs1Idx,
   output logic [4:0]         rs2Idx,
   output logic               altBit,
   output logic               instrBit5,
   output logic [`XLEN-1:0]   immI,
   output logic [`XLEN-1:0]   immS,
   output logic [`XLEN-1:0]   immB,
   output logic [`XLEN-1:0]   immU,
   output logic [`XLEN-1:0]   immJ
);
   import rvPkg::*;

   // Bits 4:0 hold the opcode, already classified into opGroup
   logic [`XLEN-1:5] instrWord;

   // Register and classify on the cycle the word arrives
   always_ff @(posedge clk) begin
      if (capture) begin
         instrWord <= memRdata[`XLEN-1:5];
         case (memRdata[6:2])
            5'b00000: opGroup <= opLoad;
            5'b01000: opGroup <= opStore;
            5'b00100: opGroup <= opAluImm;
            5'b01100: opGroup <= opAluReg;
            5'b01101: opGroup <= opLui;
            5'b00101: opGroup <= opAuipc;
            5'b11000: opGroup <= opBranch;
            5'b11011: opGroup <= opJal;
            5'b11001: opGroup <= opJalr;
            // SYSTEM and anything else run as a no-op
            default:  opGroup <= opIllegal;
         endcase
      end
   end

   // Source indices straight from the bus so the operand latch
   // can read the array in the same cycle
   assign rs1Idx = memRdata[19:15];
   assign rs2Idx = memRdata[24:20];

   // Destination comes from the held word
   assign rdIdx = instrWord[11:7];

   assign funct3    = aluOp_t'(instrWord[14:12]);
   // Set for SUB and SRA
   assign altBit    = instrWord[30];
   // Separates register forms from immediate forms
   assign instrBit5 = instrWord[5];

   // Sign-extended immediates, all from bit 31
   assign immI = {{21{instrWord[31]}}, instrWord[30:20]};
   assign immS = {{21{instrWord[31]}}, instrWord[30:25], instrWord[11:7]};
   assign immB = {{20{instrWord[31]}}, instrWord[7], instrWord[30:25],
                  instrWord[11:8], 1'b0};
   // Upper immediate, low 12 bits clear
   assign immU = {instrWord[31:12], 12'b0};
   assign immJ = {{12{instrWord[31]}}, instrWord[19:12], instrWord[20],
                  instrWord[30:21], 1'b0};

endmodule

//--- source/registerFile.sv
// Integer register file
`include "core_defs.svh"

module registerFile (
   input  logic              clk,
   input  logic              capture,
   input  logic [4:0]        rs1Idx,
   input  logic [4:0]        rs2Idx,
   input  logic [4:0]        rdIdx,
   input  logic              writeEn,
   input  logic [`XLEN-1:0]  writeData,
   output logic [`XLEN-1:0]  rs1Val,
   output logic [`XLEN-1:0]  rs2Val
);

   logic [`XLEN-1:0] regArray [`NUM_REGS];

   // Operand latch, loaded with the fetched word
   // x0 is never written, so its slot is forced to zero on read
   always_ff @(posedge clk) begin
      if (capture) begin
         rs1Val <= (rs1Idx == 5'd0) ? '0 : regArray[rs1Idx];
         rs2Val <= (rs2Idx == 5'd0) ? '0 : regArray[rs2Idx];
      end
   end

   // Single write port
   always_ff @(posedge clk) begin
      if (writeEn && (rdIdx != 5'd0)) begin
         regArray[rdIdx] <= writeData;
      end
   end

endmodule

//--- source/intAlu.sv
// Integer ALU and branch compare
`include "core_defs.svh"

module intAlu (
   input  logic              clk,
   input  logic [`XLEN-1:0]  rs1Val,
   input  logic [`XLEN-1:0]  rs2Val,
   input  logic [`XLEN-1:0]  immI,
   input  rvPkg::opGroup_t   opGroup,
   input  rvPkg::aluOp_t     funct3,
   input  logic              altBit,
   input  logic              instrBit5,
   output logic [`XLEN-1:0]  aluSum,
   output logic [`XLEN-1:0]  aluResult,
   output logic              takeBranch
);
   import rvPkg::*;

   logic [`XLEN-1:0]        operand2;
   logic [`XLEN:0]          diff;
   logic                    lessSigned;
   logic                    lessUnsigned;
   logic                    isEqual;
   logic [`XLEN-1:0]        shiftIn;
   logic signed [`XLEN:0]   shiftExt;
   logic [`XLEN:0]          shiftOut;
   logic [`XLEN-1:0]        resultNext;
   logic                    predicate;

   // Bit reversal, lets the right shifter also shift left
   function automatic logic [`XLEN-1:0] flipWord(input logic [`XLEN-1:0] x);
      logic [`XLEN-1:0] y;
      for (int i = 0; i < `XLEN; i++) begin
         y[i] = x[`XLEN-1-i];
      end
      return y;
   endfunction

   // Register forms and branches take rs2, all others take immI
   assign operand2 = ((opGroup == opAluReg) || (opGroup == opBranch)) ? rs2Val : immI;

   // Adder, also the JALR target
   assign aluSum = rs1Val + operand2;

   // One subtract for SUB and every compare
   // Top bit is the borrow, i.e. unsigned less-than
   assign diff         = {1'b0, rs1Val} - {1'b0, operand2};
   assign lessUnsigned = diff[`XLEN];
   assign lessSigned   = (rs1Val[`XLEN-1] ^ operand2[`XLEN-1]) ? rs1Val[`XLEN-1]
                                                               : diff[`XLEN];
   assign isEqual      = (diff[`XLEN-1:0] == '0);

   // Shared shifter
   // Sign fill only for SRA/SRAI
   assign shiftIn  = (funct3 == aluSll) ? flipWord(rs1Val) : rs1Val;
   assign shiftExt = {altBit & rs1Val[`XLEN-1], shiftIn};
   assign shiftOut = shiftExt >>> operand2[4:0];

   always_comb begin
      case (funct3)
         // SUB needs bit 5 too, ADDI immediates can have bit 30 set
         aluAddSub: resultNext = (altBit && instrBit5) ? diff[`XLEN-1:0] : aluSum;
         aluSll:    resultNext = flipWord(shiftOut[`XLEN-1:0]);
         aluSlt:    resultNext = {{(`XLEN-1){1'b0}}, lessSigned};
         aluSltu:   resultNext = {{(`XLEN-1){1'b0}}, lessUnsigned};
         aluXor:    resultNext = rs1Val ^ operand2;
         aluSrlSra: resultNext = shiftOut[`XLEN-1:0];
         aluOr:     resultNext = rs1Val | operand2;
         default:   resultNext = rs1Val & operand2;
      endcase
   end

   // Branch predicate, funct3 0/1 EQ/NE, 4/5 LT/GE, 6/7 LTU/GEU
   always_comb begin
      case (funct3)
         aluAddSub: predicate = isEqual;
         aluSll:    predicate = !isEqual;
         aluXor:    predicate = lessSigned;
         aluSrlSra: predicate = !lessSigned;
         aluOr:     predicate = lessUnsigned;
         aluAnd:    predicate = !lessUnsigned;
         default:   predicate = 1'b0;
      endcase
   end

   // Operands hold still from capture on
   // so the value taken in stExecute1 stays valid for stExecute2
   always_ff @(posedge clk) begin
      aluResult  <= resultNext;
      takeBranch <= (opGroup == opBranch) && predicate;
   end

endmodule

//--- source/loadStoreAlign.sv
// Load and store lane alignment
`include "core_defs.svh"

module loadStoreAlign (
   input  logic [1:0]        lsAddrLow,
   input  rvPkg::aluOp_t     funct3,
   input  logic [`XLEN-1:0]  memRdata,
   input  logic [`XLEN-1:0]  rs2Val,
   output logic [`XLEN-1:0]  loadData,
   output logic [`XLEN-1:0]  storeData,
   output logic [3:0]        storeMask
);

   logic [2:0]  sizeBits;
   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] halfLane;
   logic [7:0]  byteLane;
   logic        loadSign;

   // funct3 low bits give the size, 00 byte, 01 half, 10 word
   assign sizeBits   = funct3;
   assign byteAccess = (sizeBits[1:0] == 2'b00);
   assign halfAccess = (sizeBits[1:0] == 2'b01);

   // Pick the half, then the byte within it
   assign halfLane = lsAddrLow[1] ? memRdata[31:16] : memRdata[15:0];
   assign byteLane = lsAddrLow[0] ? halfLane[15:8] : halfLane[7:0];

   // LBU/LHU set funct3 bit 2
   assign loadSign = !sizeBits[2] & (byteAccess ? byteLane[7] : halfLane[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, byteLane} :
                     halfAccess ? {{16{loadSign}}, halfLane} :
                                  memRdata;

   // Low bytes repeated in every lane, the mask picks the live one
   assign storeData = byteAccess ? {4{rs2Val[7:0]}} :
                      halfAccess ? {2{rs2Val[15:0]}} :
                                   rs2Val;

   // One-hot for bytes, a pair for halfwords
   assign storeMask = byteAccess ? (4'b0001 << lsAddrLow) :
                      halfAccess ? (lsAddrLow[1] ? 4'b1100 : 4'b0011) :
                                   4'b1111;

endmodule

//--- source/coreControl.sv
// Core sequencer and program counter
`include "core_defs.svh"

module coreControl (
   input  logic                clk,
   input  logic                reset,
   input  logic                memRbusy,
   input  logic                memWbusy,
   input  rvPkg::opGroup_t     opGroup,
   input  logic [`XLEN-1:0]    immI,
   input  logic [`XLEN-1:0]    immS,
   input  logic [`XLEN-1:0]    immB,
   input  logic [`XLEN-1:0]    immU,
   input  logic [`XLEN-1:0]    immJ,
   input  logic [`XLEN-1:0]    rs1Val,
   input  logic [`XLEN-1:0]    aluSum,
   input  logic [`XLEN-1:0]    aluResult,
   input  logic                takeBranch,
   input  logic [`XLEN-1:0]    loadData,
   input  logic [3:0]          storeMask,
   output rvPkg::coreState_t   state,
   output logic                capture,
   output logic [`XLEN-1:0]    memAddr,
   output logic                memRstrb,
   output logic [3:0]          memWmask,
   output logic [1:0]          lsAddrLow,
   output logic                writeEn,
   output logic [`XLEN-1:0]    writeData
);
   import rvPkg::*;

   localparam int addrPad = `XLEN - `ADDR_WIDTH;
   localparam logic [`XLEN-1:0] resetAddrFull = `RESET_ADDR;
   localparam logic [`ADDR_WIDTH-1:0] pcStep = 4;

   logic [`ADDR_WIDTH-1:0] pc;
   logic [`ADDR_WIDTH-1:0] pcPlus4;
   logic [`ADDR_WIDTH-1:0] pcPlusImm;
   logic [`ADDR_WIDTH-1:0] lsAddr;
   logic                   isLoad;
   logic                   isStore;
   logic                   writesRd;
   logic                   memIdle;
   logic                   loadPending;

   assign isLoad   = (opGroup == opLoad);
   assign isStore  = (opGroup == opStore);
   // Groups that leave a result in rd at stExecute2
   assign writesRd = (opGroup == opAluImm) || (opGroup == opAluReg) ||
                     (opGroup == opLui)    || (opGroup == opAuipc)  ||
                     (opGroup == opJal)    || (opGroup == opJalr);
   assign memIdle  = !memRbusy && !memWbusy;
   assign pcPlus4  = pc + pcStep;

   // Fetch address until the word is in, then the data address
   assign memAddr = {{addrPad{1'b0}},
                     ((state == stFetch) || (state == stWaitInstr)) ? pc : lsAddr};
   assign lsAddrLow = lsAddr[1:0];

   assign capture  = (state == stWaitInstr) && !memRbusy;
   assign memRstrb = (state == stFetch) || ((state == stExecute2) && isLoad);
   // Single write cycle
   assign memWmask = ((state == stExecute2) && isStore) ? storeMask : 4'b0000;

   // Non-memory results at stExecute2, loads once the bus is idle
   assign writeEn = ((state == stExecute2) && writesRd) ||
                    ((state == stWaitMem) && loadPending && memIdle);

   always_comb begin
      case (opGroup)
         opLui:    writeData = immU;
         opAuipc:  writeData = {{addrPad{1'b0}}, pcPlusImm};
         opJal,
         opJalr:   writeData = {{addrPad{1'b0}}, pcPlus4};
         opAluImm,
         opAluReg: writeData = aluResult;
         opLoad:   writeData = loadData;
         default:  writeData = '0;
      endcase
   end

   // Target and address adders, loaded in stExecute1
   always_ff @(posedge clk) begin
      if (state == stExecute1) begin
         pcPlusImm <= pc + ((opGroup == opJal)   ? immJ[`ADDR_WIDTH-1:0] :
                            (opGroup == opAuipc) ? immU[`ADDR_WIDTH-1:0] :
                                                   immB[`ADDR_WIDTH-1:0]);
         lsAddr    <= rs1Val[`ADDR_WIDTH-1:0] +
                      (isStore ? immS[`ADDR_WIDTH-1:0] : immI[`ADDR_WIDTH-1:0]);
      end
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Start by draining any write still in progress
         state       <= stWaitMem;
         pc          <= resetAddrFull[`ADDR_WIDTH-1:0];
         loadPending <= 1'b0;
      end else begin
         case (state)
            stFetch: state <= stWaitInstr;
            stWaitInstr: begin
               if (!memRbusy) begin
                  state <= stExecute1;
               end
            end
            stExecute1: state <= stExecute2;
            stExecute2: begin
               // JALR target has bit 0 cleared
               if (opGroup == opJalr) begin
                  pc <= {aluSum[`ADDR_WIDTH-1:1], 1'b0};
               end else if ((opGroup == opJal) || takeBranch) begin
                  pc <= pcPlusImm;
               end else begin
                  pc <= pcPlus4;
               end
               loadPending <= isLoad;
               state       <= (isLoad || isStore) ? stWaitMem : stFetch;
            end
            stWaitMem: begin
               if (memIdle) begin
                  loadPending <= 1'b0;
                  state       <= stFetch;
               end
            end
            default: state <= stFetch;
         endcase
      end
   end

endmodule

//--- source/rv32Core.sv
// RV32I core top level
`include "core_defs.svh"

module rv32Core (
   input  logic              clk,
   input  logic              reset,
   input  logic [`XLEN-1:0]  memRdata,
   input  logic              memRbusy,
   input  logic              memWbusy,
   output logic [`XLEN-1:0]  memAddr,
   output logic [`XLEN-1:0]  memWdata,
   output logic [3:0]        memWmask,
   output logic              memRstrb
);
   import rvPkg::*;

   // Decoder fields
   opGroup_t          opGroup;
   aluOp_t            funct3;
   logic [4:0]        rdIdx;
   logic [4:0]        rs1Idx;
   logic [4:0]        rs2Idx;
   logic              altBit;
   logic              instrBit5;
   logic [`XLEN-1:0]  immI;
   logic [`XLEN-1:0]  immS;
   logic [`XLEN-1:0]  immB;
   logic [`XLEN-1:0]  immU;
   logic [`XLEN-1:0]  immJ;

   // Operands and results
   logic [`XLEN-1:0]  rs1Val;
   logic [`XLEN-1:0]  rs2Val;
   logic [`XLEN-1:0]  aluSum;
   logic [`XLEN-1:0]  aluResult;
   logic              takeBranch;
   logic [`XLEN-1:0]  loadData;
   logic [3:0]        storeMask;

   // Sequencing
   logic              capture;
   logic [1:0]        lsAddrLow;
   logic              writeEn;
   logic [`XLEN-1:0]  writeData;

   instrDecoder uDecoder (
      .clk(clk), .capture(capture), .memRdata(memRdata),
      .opGroup(opGroup), .funct3(funct3),
      .rdIdx(rdIdx), .rs1Idx(rs1Idx), .rs2Idx(rs2Idx),
      .altBit(altBit), .instrBit5(instrBit5),
      .immI(immI), .immS(immS), .immB(immB), .immU(immU), .immJ(immJ)
   );

   registerFile uRegs (
      .clk(clk), .capture(capture),
      .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rdIdx(rdIdx),
      .writeEn(writeEn), .writeData(writeData),
      .rs1Val(rs1Val), .rs2Val(rs2Val)
   );

   intAlu uAlu (
      .clk(clk), .rs1Val(rs1Val), .rs2Val(rs2Val), .immI(immI),
      .opGroup(opGroup), .funct3(funct3),
      .altBit(altBit), .instrBit5(instrBit5),
      .aluSum(aluSum), .aluResult(aluResult), .takeBranch(takeBranch)
   );

   // Store data goes straight out on the bus
   loadStoreAlign uAlign (
      .lsAddrLow(lsAddrLow), .funct3(funct3),
      .memRdata(memRdata), .rs2Val(rs2Val),
      .loadData(loadData), .storeData(memWdata), .storeMask(storeMask)
   );

   // State is internal only
   coreControl uControl (
      .clk(clk), .reset(reset),
      .memRbusy(memRbusy), .memWbusy(memWbusy),
      .opGroup(opGroup),
      .immI(immI), .immS(immS), .immB(immB), .immU(immU), .immJ(immJ),
      .rs1Val(rs1Val), .aluSum(aluSum), .aluResult(aluResult),
      .takeBranch(takeBranch), .loadData(loadData), .storeMask(storeMask),
      .state(), .capture(capture),
      .memAddr(memAddr), .memRstrb(memRstrb), .memWmask(memWmask),
      .lsAddrLow(lsAddrLow), .writeEn(writeEn), .writeData(writeData)
   );

endmodule

//--- verif/coreTb.sv
// RV32I core testbench
`include "core_defs.svh"

module coreTb;

   localparam int memWords = 256;
   localparam int fileWords = 256;
   localparam logic [`XLEN-1:0] sectionEnd = 32'hFFFF_FFFF;

   logic              clk;
   logic              reset;
   logic [`XLEN-1:0]  memRdata;
   logic              memRbusy;
   logic              memWbusy;
   logic [`XLEN-1:0]  memAddr;
   logic [`XLEN-1:0]  memWdata;
   logic [3:0]        memWmask;
   logic              memRstrb;

   // Word memory indexed by byte address bits 9:2
   logic [`XLEN-1:0]  mem [memWords];
   logic [`XLEN-1:0]  fileData [fileWords];

   // Expected store records in program order
   logic [`XLEN-1:0]  expAddr [$];
   logic [`XLEN-1:0]  expData [$];
   logic [3:0]        expMask [$];

   int                progWords;
   int                storeCount;
   int                errors;
   int                rbusyLeft;
   int                wbusyLeft;
   logic [31:0]       lfsr;
   logic              firstFetch;
   // Word of the read in progress
   logic [`XLEN-1:0]  readWord;

   rv32Core DUT (
      .clk(clk), .reset(reset),
      .memRdata(memRdata), .memRbusy(memRbusy), .memWbusy(memWbusy),
      .memAddr(memAddr), .memWdata(memWdata), .memWmask(memWmask),
      .memRstrb(memRstrb)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // Busy length of 0 to 3 cycles from two LFSR steps
   task automatic drawBusy(output int n);
      lfsr = lfsrStep(lfsr);
      n = lfsr[0];
      lfsr = lfsrStep(lfsr);
      n = n * 2 + lfsr[0];
   endtask

   task automatic checkWord(input string name, input logic [`XLEN-1:0] got,
                            input logic [`XLEN-1:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic checkMask(input string name, input logic [3:0] got,
                            input logic [3:0] exp);
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // Memory model sampling the bus on the rising edge
   always @(posedge clk) begin
      int n;
      if (reset) begin
         // No new request until the memory is idle again
         if ((memWbusy || memRbusy) && ((memWmask != 4'b0000) || memRstrb)) begin
            errors++;
            $display("Bus request at %0t while the memory was still busy", $time);
         end
         if (memWmask != 4'b0000) begin
            if (storeCount < expAddr.size()) begin
               checkWord("memAddr", memAddr, expAddr[storeCount]);
               checkWord("memWdata", memWdata, expData[storeCount]);
               checkMask("memWmask", memWmask, expMask[storeCount]);
            end else begin
               errors++;
               $display("Unexpected extra store at %0t to address %h", $time, memAddr);
            end
            storeCount++;
            for (int b = 0; b < 4; b++) begin
               if (memWmask[b]) begin
                  mem[memAddr[9:2]][b*8 +: 8] = memWdata[b*8 +: 8];
               end
            end
            drawBusy(n);
            wbusyLeft = n;
            memWbusy <= (n > 0);
         end else if (wbusyLeft > 0) begin
            wbusyLeft--;
            memWbusy <= (wbusyLeft > 0);
         end
         if (memRstrb) begin
            // First fetch must come from the reset address
            if (firstFetch) begin
               checkWord("memAddr", memAddr, `RESET_ADDR);
               firstFetch = 1'b0;
            end
            readWord = mem[memAddr[9:2]];
            drawBusy(n);
            rbusyLeft = n;
            memRbusy <= (n > 0);
            // Data bus holds junk while busy
            memRdata <= (n > 0) ? ~readWord : readWord;
         end else if (rbusyLeft > 0) begin
            rbusyLeft--;
            memRbusy <= (rbusyLeft > 0);
            if (rbusyLeft == 0) begin
               memRdata <= readWord;
            end
         end
      end
   end

   // Watchdog scaled by program length
   initial begin
      #1;
      repeat (progWords * 20 + 200) @(posedge clk);
      $display("Timeout, only %0d of %0d stores seen", storeCount, expAddr.size());
      $display("Some tests failed");
      $finish;
   end

   initial begin
      int idx;
      reset = 1'b0;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      errors = 0;
      storeCount = 0;
      rbusyLeft = 0;
      wbusyLeft = 0;
      lfsr = 32'h27d9;
      firstFetch = 1'b1;
      readWord = '0;
      for (int i = 0; i < memWords; i++) begin
         mem[i] = '0;
      end
      for (int i = 0; i < fileWords; i++) begin
         fileData[i] = sectionEnd;
      end
      $readmemh("verif/program_input.hex", fileData);
      // Program words up to the first marker
      idx = 0;
      while (idx < fileWords && fileData[idx] != sectionEnd) begin
         mem[idx] = fileData[idx];
         idx++;
      end
      progWords = idx;
      idx++;
      // Then address, data, mask triples up to the next marker
      while (idx + 2 < fileWords && fileData[idx] != sectionEnd) begin
         expAddr.push_back(fileData[idx]);
         expData.push_back(fileData[idx + 1]);
         expMask.push_back(fileData[idx + 2][3:0]);
         idx += 3;
      end
      repeat (10) @(posedge clk);
      reset <= 1'b1;
      wait (storeCount >= expAddr.size());
      // Extra cycles to catch any stray store
      repeat (50) @(posedge clk);
      $display("Errors: %0d, stores seen: %0d of %0d", errors, storeCount, expAddr.size());
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- verif/program_input.hex
// Program words from address 0, then ffffffff
// Then store records (address data mask), then ffffffff
20000513 FFB00093 00300113 402081B3
00352023 00209233 00452223 4010D293
00552423 0020D333 00652623 0020A3B3
0020B433 00752823 00852A23 0F00C493
00710013 00052C23 00952E23 123455B7
00001617 02B52023 02C52223 00210463
06152E23 00211463 02252423 0020C463
06152E23 0020E463 0080076F 06152E23
02E52623 00000797 00D78867 06152E23
03052823 80F188B7 F0288893 05152023
04050903 04150983 04250A03 04354A83
04051B03 04251B83 04255C03 04052C83
05252223 05352423 05452623 05552823
05652A23 05752C23 05852E23 07952023
071504A3 07151723 0000006F
FFFFFFFF
00000200 FFFFFFF8 0000000F
00000204 FFFFFFD8 0000000F
00000208 FFFFFFFD 0000000F
0000020C 1FFFFFFF 0000000F
00000210 00000001 0000000F
00000214 00000000 0000000F
00000218 00000000 0000000F
0000021C FFFFFF0B 0000000F
00000220 12345000 0000000F
00000224 00001050 0000000F
00000228 00000003 0000000F
0000022C 0000007C 0000000F
00000230 0000008C 0000000F
00000240 80F17F02 0000000F
00000244 00000002 0000000F
00000248 0000007F 0000000F
0000024C FFFFFFF1 0000000F
00000250 00000080 0000000F
00000254 00007F02 0000000F
00000258 FFFF80F1 0000000F
0000025C 000080F1 0000000F
00000260 80F17F02 0000000F
00000269 02020202 00000002
0000026E 7F027F02 0000000C
FFFFFFFF

//--- src.f
+incdir+common
common/rvPkg.sv
source/instrDecoder.sv
source/registerFile.sv
source/intAlu.sv
source/loadStoreAlign.sv
source/coreControl.sv
source/rv32Core.sv
verif/coreTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= coreTb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal
PASS_MSG ?= All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
